// File: common/sim_defines.svh
`ifndef SIM_DEFINES_SVH
`define SIM_DEFINES_SVH

//////////////////////////////////////////////////
// Memory map
//////////////////////////////////////////////////

`define SIM_PC_START    64'h0000_0000_8000_0000 // Reset PC, also RAM word 0
`define SIM_RAM_WORDS   1024                    // 64-bit words

//////////////////////////////////////////////////
// Core
//////////////////////////////////////////////////

`define SIM_NUM_REGS    32
`define SIM_TRAP_OPCODE 7'h6b                   // Custom opcode, ends the run

`endif

// File: common/sim_pkg.sv
package sim_pkg;

  //////////////////////////////////////////////////
  // Core to RAM
  //////////////////////////////////////////////////

  typedef struct packed {
    logic        cen;   // Access strobe
    logic        wen;
    logic [63:0] addr;  // Byte address
    logic [63:0] wdata;
    logic [7:0]  wmask; // One bit per byte lane
    logic [2:0]  size;  // log2 of byte count
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [63:0] rdata;
  } mem_rsp_t;

  //////////////////////////////////////////////////
  // Commit and trap records
  //////////////////////////////////////////////////

  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    logic [31:0] inst;
    logic        wen;
    logic [4:0]  wdest;
    logic [63:0] wdata;
  } commit_t;

  typedef struct packed {
    logic        valid;
    logic [7:0]  code;  // a0[7:0] at the trap
    logic [63:0] pc;
    logic [63:0] cycle_cnt;
    logic [63:0] instr_cnt;
  } trap_t;

endpackage

// File: core/reg_file.sv
`timescale 1ns/100ps
`include "sim_defines.svh"

module reg_file (
  input  logic        clock,
  input  logic        reset,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [63:0] wdata_i,
  input  logic [4:0]  raddr1_i,
  input  logic [4:0]  raddr2_i,
  output logic [63:0] rdata1_o,
  output logic [63:0] rdata2_o,
  output logic [63:0] a0_o
);

  logic [63:0] regs_q [0:`SIM_NUM_REGS-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `SIM_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != 5'd0) begin // x0 stays zero
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];
  assign a0_o     = regs_q[10]; // Trap code source

  // x0 reads as zero
  a_x0_zero: assert property (@(posedge clock) disable iff (reset)
    raddr1_i == 5'd0 |-> rdata1_o == 64'd0);

endmodule

// File: core/mini_core.sv
`timescale 1ns/100ps
`include "sim_defines.svh"

module mini_core (
  input  logic              clock,
  input  logic              reset,
  input  logic              run_i,
  output sim_pkg::mem_req_t mem_req_o,
  input  sim_pkg::mem_rsp_t mem_rsp_i,
  output sim_pkg::commit_t  retire_o,
  output logic [63:0]       a0_o,
  input  logic              halt_i
);

  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_FETCH_W,
    S_EXEC,
    S_MEM,
    S_MEM_W,
    S_WB
  } state_t;

  state_t      state_q;
  logic [63:0] pc_q;
  logic [63:0] next_pc_q;
  logic [31:0] inst_q;
  logic [63:0] result_q;
  logic [63:0] maddr_q;
  logic [63:0] wdata_q;
  logic [7:0]  wmask_q;
  logic [2:0]  size_q;

  logic [63:0] rs1_val;
  logic [63:0] rs2_val;
  logic [63:0] imm_i, imm_s, imm_b, imm_j;
  logic [63:0] ld_addr, st_addr;
  logic        is_addi, is_add, is_ld, is_sd, is_sb, is_beq, is_jal, is_trap;
  logic        is_store, rd_wen, in_mem;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign is_addi = inst_q[6:0] == OP_IMM && inst_q[14:12] == 3'b000;
  assign is_add  = inst_q[6:0] == OP_REG && inst_q[14:12] == 3'b000 && inst_q[31:25] == 7'd0;
  assign is_ld   = inst_q[6:0] == OP_LOAD && inst_q[14:12] == 3'b011;
  assign is_sd   = inst_q[6:0] == OP_STORE && inst_q[14:12] == 3'b011;
  assign is_sb   = inst_q[6:0] == OP_STORE && inst_q[14:12] == 3'b000;
  assign is_beq  = inst_q[6:0] == OP_BRANCH && inst_q[14:12] == 3'b000;
  assign is_jal  = inst_q[6:0] == OP_JAL;
  assign is_trap = inst_q[6:0] == `SIM_TRAP_OPCODE;

  assign is_store = is_sd | is_sb;
  assign rd_wen   = is_addi | is_add | is_ld | is_jal;

  assign imm_i = {{52{inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{52{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{51{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_j = {{43{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  assign ld_addr = rs1_val + imm_i;
  assign st_addr = rs1_val + imm_s;

  reg_file i_reg_file (
    .clock    (clock),
    .reset    (reset),
    .we_i     (state_q == S_WB && rd_wen),
    .waddr_i  (inst_q[11:7]),
    .wdata_i  (result_q),
    .raddr1_i (inst_q[19:15]),
    .raddr2_i (inst_q[24:20]),
    .rdata1_o (rs1_val),
    .rdata2_o (rs2_val),
    .a0_o     (a0_o)
  );

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= S_IDLE;
      pc_q    <= `SIM_PC_START;
    end else begin
      case (state_q)
        S_IDLE:    if (run_i && !halt_i) state_q <= S_FETCH;
        S_FETCH:   state_q <= S_FETCH_W;
        S_FETCH_W: if (mem_rsp_i.ready) state_q <= S_EXEC;
        S_EXEC:    state_q <= (is_ld || is_store) ? S_MEM : S_WB;
        S_MEM:     state_q <= S_MEM_W;
        S_MEM_W:   if (mem_rsp_i.ready) state_q <= S_WB;
        S_WB: begin
          pc_q    <= next_pc_q;
          state_q <= (run_i && !is_trap) ? S_FETCH : S_IDLE; // Trap parks the core
        end
        default:   state_q <= S_IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clock) begin
    if (state_q == S_FETCH_W && mem_rsp_i.ready) begin
      inst_q <= pc_q[2] ? mem_rsp_i.rdata[63:32] : mem_rsp_i.rdata[31:0];
    end
    if (state_q == S_EXEC) begin
      next_pc_q <= pc_q + 64'd4;
      result_q  <= rs1_val + imm_i;
      maddr_q   <= is_ld ? ld_addr : st_addr;
      wdata_q   <= rs2_val;
      wmask_q   <= 8'hff;
      size_q    <= 3'd3;
      if (is_add) result_q <= rs1_val + rs2_val;
      if (is_sb) begin
        wdata_q <= rs2_val << {st_addr[2:0], 3'b000}; // Byte into its lane
        wmask_q <= 8'b1 << st_addr[2:0];
        size_q  <= 3'd0;
      end
      if (is_beq && rs1_val == rs2_val) next_pc_q <= pc_q + imm_b;
      if (is_jal) begin
        result_q  <= pc_q + 64'd4; // Link value
        next_pc_q <= pc_q + imm_j;
      end
    end
    if (state_q == S_MEM_W && mem_rsp_i.ready && is_ld) begin
      result_q <= mem_rsp_i.rdata;
    end
  end

  //////////////////////////////////////////////////
  // Memory port and retire record
  //////////////////////////////////////////////////

  assign in_mem = state_q == S_MEM || state_q == S_MEM_W;

  always_comb begin
    mem_req_o.cen   = state_q == S_FETCH || state_q == S_MEM;
    mem_req_o.wen   = state_q == S_MEM && is_store;
    mem_req_o.addr  = in_mem ? maddr_q : pc_q;
    mem_req_o.wdata = wdata_q;
    mem_req_o.wmask = mem_req_o.wen ? wmask_q : 8'h00;
    mem_req_o.size  = in_mem ? size_q : 3'd2;
  end

  always_comb begin
    retire_o.valid = state_q == S_WB;
    retire_o.pc    = pc_q;
    retire_o.inst  = inst_q;
    retire_o.wen   = rd_wen && inst_q[11:7] != 5'd0;
    retire_o.wdest = inst_q[11:7];
    retire_o.wdata = result_q;
  end

  // No access and no answer pending while parked
  a_idle_quiet: assert property (@(posedge clock) disable iff (reset)
    state_q == S_IDLE |-> !mem_req_o.cen && !mem_rsp_i.ready);

  a_store_mask: assert property (@(posedge clock) disable iff (reset)
    mem_req_o.cen && mem_req_o.wen |-> mem_req_o.wmask != 8'h00);

endmodule

// File: rtl/ram_bridge.sv
`timescale 1ns/100ps
`include "sim_defines.svh"

module ram_bridge (
  input  logic              clock,
  input  logic              reset,
  input  sim_pkg::mem_req_t req_i,
  output sim_pkg::mem_rsp_t rsp_o,
  input  logic              load_we_i,
  input  logic [9:0]        load_addr_i,
  input  logic [63:0]       load_data_i
);

  localparam int IDX_W = $clog2(`SIM_RAM_WORDS);

  logic [63:0]      mem_q [0:`SIM_RAM_WORDS-1];
  logic [63:0]      word_off;
  logic [IDX_W-1:0] word_idx;
  logic [63:0]      bit_mask;
  logic [63:0]      rdata_q;
  logic             ready_q;

  //////////////////////////////////////////////////
  // Address and mask
  //////////////////////////////////////////////////

  assign word_off = (req_i.addr - `SIM_PC_START) >> 3;
  assign word_idx = word_off[IDX_W-1:0];

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      bit_mask[8*i +: 8] = {8{req_i.wmask[i]}}; // Byte enable to bit enable
    end
  end

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (load_we_i) begin
      mem_q[load_addr_i] <= load_data_i; // Program load, core idle
    end else if (req_i.cen && req_i.wen) begin
      mem_q[word_idx] <= (mem_q[word_idx] & ~bit_mask) | (req_i.wdata & bit_mask);
    end
  end

  always_ff @(posedge clock) begin
    if (req_i.cen && !req_i.wen) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  // Ready one cycle after every strobe
  always_ff @(posedge clock) begin
    if (reset) ready_q <= 1'b0;
    else       ready_q <= req_i.cen;
  end

  assign rsp_o.ready = ready_q;
  assign rsp_o.rdata = rdata_q;

  a_in_window: assert property (@(posedge clock) disable iff (reset)
    req_i.cen |-> req_i.addr >= `SIM_PC_START &&
                  req_i.addr < `SIM_PC_START + 64'(`SIM_RAM_WORDS * 8));

endmodule

// File: rtl/commit_monitor.sv
`timescale 1ns/100ps
`include "sim_defines.svh"

module commit_monitor (
  input  logic             clock,
  input  logic             reset,
  input  sim_pkg::commit_t retire_i,
  input  logic [63:0]      a0_i,
  output sim_pkg::commit_t commit_o,
  output sim_pkg::trap_t   trap_o,
  output logic             halt_o
);

  sim_pkg::commit_t commit_q;
  logic             commit_valid_q;
  logic             trap_valid_q;
  logic [7:0]       trap_code_q;
  logic [63:0]      trap_pc_q;
  logic [63:0]      cycle_cnt_q;
  logic [63:0]      instr_cnt_q;
  logic             is_trap;

  assign is_trap = retire_i.valid && retire_i.inst[6:0] == `SIM_TRAP_OPCODE;

  //////////////////////////////////////////////////
  // Commit record
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    commit_q <= retire_i; // Payload, valid kept separately
  end

  always_ff @(posedge clock) begin
    if (reset) commit_valid_q <= 1'b0;
    else       commit_valid_q <= retire_i.valid && !trap_valid_q;
  end

  //////////////////////////////////////////////////
  // Trap latch and counters
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      trap_valid_q <= 1'b0;
      cycle_cnt_q  <= '0;
      instr_cnt_q  <= '0;
    end else if (!trap_valid_q) begin // Frozen after the trap
      cycle_cnt_q <= cycle_cnt_q + 64'd1;
      instr_cnt_q <= instr_cnt_q + 64'(retire_i.valid);
      if (is_trap) trap_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (is_trap && !trap_valid_q) begin
      trap_code_q <= a0_i[7:0];
      trap_pc_q   <= retire_i.pc;
    end
  end

  always_comb begin
    commit_o       = commit_q;
    commit_o.valid = commit_valid_q;
  end

  assign trap_o = '{valid:     trap_valid_q,
                    code:      trap_code_q,
                    pc:        trap_pc_q,
                    cycle_cnt: cycle_cnt_q,
                    instr_cnt: instr_cnt_q};

  assign halt_o = trap_valid_q;

endmodule

// File: rtl/sim_top.sv
`timescale 1ns/100ps

module sim_top (
  input  logic             clock,
  input  logic             reset,
  input  logic             run_i,
  input  logic             load_we_i,
  input  logic [9:0]       load_addr_i,
  input  logic [63:0]      load_data_i,
  output sim_pkg::commit_t commit_o,
  output sim_pkg::trap_t   trap_o
);

  sim_pkg::mem_req_t mem_req;
  sim_pkg::mem_rsp_t mem_rsp;
  sim_pkg::commit_t  retire;
  logic [63:0]       a0;
  logic              halt;

  mini_core i_mini_core (
    .clock     (clock),
    .reset     (reset),
    .run_i     (run_i),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp),
    .retire_o  (retire),
    .a0_o      (a0),
    .halt_i    (halt)
  );

  ram_bridge i_ram_bridge (
    .clock       (clock),
    .reset       (reset),
    .req_i       (mem_req),
    .rsp_o       (mem_rsp),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

  commit_monitor i_commit_monitor (
    .clock    (clock),
    .reset    (reset),
    .retire_i (retire),
    .a0_i     (a0),
    .commit_o (commit_o),
    .trap_o   (trap_o),
    .halt_o   (halt)
  );

endmodule

// File: bench/tb_sim_top.sv
`timescale 1ns/100ps
`include "sim_defines.svh"

module tb_sim_top;

  localparam time DRIVE_DELAY = 1ns;

  logic             clock;
  logic             reset;
  logic             run_i;
  logic             load_we_i;
  logic [9:0]       load_addr_i;
  logic [63:0]      load_data_i;
  sim_pkg::commit_t commit_o;
  sim_pkg::trap_t   trap_o;

  logic [31:0]      prog_q [$];
  sim_pkg::commit_t exp_q [$];
  int unsigned      budget_cycles = 200; // Grows by 10 per loaded instruction
  int unsigned      cycles_run = 0;
  int unsigned      reset_cycle = 0;     // cycles_run at reset release
  int unsigned      seed;

  sim_top i_sim_top (
    .clock       (clock),
    .reset       (reset),
    .run_i       (run_i),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .commit_o    (commit_o),
    .trap_o      (trap_o)
  );

  always #50 clock = ~clock;

  //////////////////////////////////////////////////
  // Failure handling and checks
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic check_commit(input sim_pkg::commit_t exp);
    check_value("commit_o.pc", commit_o.pc, exp.pc);
    check_value("commit_o.inst", 64'(commit_o.inst), 64'(exp.inst));
    check_value("commit_o.wen", 64'(commit_o.wen), 64'(exp.wen));
    if (exp.wen) begin
      check_value("commit_o.wdest", 64'(commit_o.wdest), 64'(exp.wdest));
      check_value("commit_o.wdata", commit_o.wdata, exp.wdata);
    end
  endtask

  initial begin : watchdog
    forever begin
      @(posedge clock);
      cycles_run++;
      if (cycles_run > budget_cycles) begin
        abort_run($sformatf("Watchdog expired after %0d cycles, the run did not finish",
                            cycles_run));
      end
    end
  end

  //////////////////////////////////////////////////
  // Instruction encoders
  //////////////////////////////////////////////////

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {7'd0, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_ld(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b011, rd, 7'b0000011};
  endfunction

  // funct3 picks SB (000) or SD (011)
  function automatic logic [31:0] enc_store(input logic [2:0] funct3, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, funct3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_trap();
    return {25'd0, `SIM_TRAP_OPCODE};
  endfunction

  //////////////////////////////////////////////////
  // Program building and running
  //////////////////////////////////////////////////

  // Appends one instruction, and its commit if it is expected to retire
  task automatic add_inst(input logic [31:0] inst, input logic retires, input logic wen,
                          input logic [4:0] rd, input logic [63:0] data);
    sim_pkg::commit_t exp;
    prog_q.push_back(inst);
    if (retires) begin
      exp.valid = 1'b1;
      exp.pc    = `SIM_PC_START + 64'(4 * (prog_q.size() - 1));
      exp.inst  = inst;
      exp.wen   = wen;
      exp.wdest = rd;
      exp.wdata = data;
      exp_q.push_back(exp);
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    #DRIVE_DELAY;
    run_i = 1'b0;
    reset = 1'b1;
    repeat (3) @(posedge clock);
    #DRIVE_DELAY;
    reset       = 1'b0;
    reset_cycle = cycles_run;
  endtask

  task automatic load_program();
    int          n_words;
    logic [31:0] hi;
    n_words = (prog_q.size() + 1) / 2;
    budget_cycles += 10 * prog_q.size();
    for (int w = 0; w < n_words; w++) begin
      hi = (2 * w + 1 < prog_q.size()) ? prog_q[2 * w + 1] : 32'd0;
      @(posedge clock);
      #DRIVE_DELAY;
      load_we_i   = 1'b1;
      load_addr_i = 10'(w);
      load_data_i = {hi, prog_q[2 * w]}; // Lower address in the low half
    end
    @(posedge clock);
    #DRIVE_DELAY;
    load_we_i = 1'b0;
  endtask

  // Runs until the trap, checking every commit in order
  task automatic run_program(output int n_commits);
    sim_pkg::commit_t exp;
    bit               trapped;
    int unsigned      trap_cycle;
    n_commits  = 0;
    trapped    = 1'b0;
    trap_cycle = 0;
    apply_reset();
    load_program();
    run_i = 1'b1;
    while (!trapped) begin
      @(negedge clock);
      if (commit_o.valid) begin
        if (exp_q.size() == 0) begin
          abort_run($sformatf("Unexpected commit at pc 0x%0h", commit_o.pc));
        end else begin
          exp = exp_q.pop_front();
          check_commit(exp);
          n_commits++;
        end
      end
      if (trap_o.valid) begin
        trapped    = 1'b1;
        trap_cycle = cycles_run - reset_cycle; // Cycles since reset release
        check_value("trap_o.cycle_cnt", trap_o.cycle_cnt, 64'(trap_cycle));
      end
    end
    if (exp_q.size() != 0) begin
      abort_run($sformatf("Trap raised with %0d expected commits still missing",
                          exp_q.size()));
    end
    repeat (10) begin // Nothing retires after the trap
      @(negedge clock);
      check_value("commit_o.valid", 64'(commit_o.valid), 64'd0);
      check_value("trap_o.valid", 64'(trap_o.valid), 64'd1);
      check_value("trap_o.cycle_cnt", trap_o.cycle_cnt, 64'(trap_cycle));
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic idle_test();
    apply_reset();
    repeat (20) begin
      @(negedge clock);
      check_value("commit_o.valid", 64'(commit_o.valid), 64'd0);
      check_value("trap_o.valid", 64'(trap_o.valid), 64'd0);
      check_value("trap_o.instr_cnt", trap_o.instr_cnt, 64'd0);
      check_value("trap_o.cycle_cnt", trap_o.cycle_cnt, 64'(cycles_run - reset_cycle));
    end
  endtask

  task automatic alu_test();
    logic [11:0] imm_a, imm_b, imm_c;
    logic [63:0] x1, x2, x3, x4, x5;
    int          n;
    prog_q.delete();
    exp_q.delete();
    imm_a = 12'($urandom());
    imm_b = 12'($urandom());
    imm_c = 12'($urandom());
    x1 = sext12(imm_a);
    x2 = sext12(imm_b);
    x3 = x1 + x2;
    x4 = x3 + sext12(imm_c);
    x5 = x4 + x1;
    add_inst(enc_addi(5'd1, 5'd0, imm_a), 1'b1, 1'b1, 5'd1, x1);
    add_inst(enc_addi(5'd2, 5'd0, imm_b), 1'b1, 1'b1, 5'd2, x2);
    add_inst(enc_add(5'd3, 5'd1, 5'd2), 1'b1, 1'b1, 5'd3, x3);
    add_inst(enc_addi(5'd4, 5'd3, imm_c), 1'b1, 1'b1, 5'd4, x4);
    add_inst(enc_add(5'd5, 5'd4, 5'd1), 1'b1, 1'b1, 5'd5, x5);
    add_inst(enc_trap(), 1'b1, 1'b0, 5'd0, 64'd0);
    run_program(n);
  endtask

  task automatic memory_test();
    logic [11:0] imm_a, imm_b;
    logic [63:0] base, x7, x8, word;
    int          n;
    prog_q.delete();
    exp_q.delete();
    imm_a = 12'($urandom());
    imm_b = 12'($urandom());
    base  = `SIM_PC_START + 64'd4; // JAL link value
    x7    = sext12(imm_a) + base;
    x8    = sext12(imm_b);
    word  = x7;
    word[31:24] = x8[7:0];         // SB hits byte 3
    add_inst(enc_jal(5'd6, 21'd4), 1'b1, 1'b1, 5'd6, base);
    add_inst(enc_addi(5'd7, 5'd0, imm_a), 1'b1, 1'b1, 5'd7, sext12(imm_a));
    add_inst(enc_add(5'd7, 5'd7, 5'd6), 1'b1, 1'b1, 5'd7, x7);
    add_inst(enc_addi(5'd8, 5'd0, imm_b), 1'b1, 1'b1, 5'd8, x8);
    add_inst(enc_store(3'b011, 5'd7, 5'd6, 12'h7fc), 1'b1, 1'b0, 5'd0, 64'd0);
    add_inst(enc_store(3'b000, 5'd8, 5'd6, 12'h7ff), 1'b1, 1'b0, 5'd0, 64'd0);
    add_inst(enc_ld(5'd9, 5'd6, 12'h7fc), 1'b1, 1'b1, 5'd9, word);
    add_inst(enc_trap(), 1'b1, 1'b0, 5'd0, 64'd0);
    run_program(n);
  endtask

  task automatic control_test();
    logic [11:0] imm_a;
    logic [63:0] xa, link;
    int          n;
    prog_q.delete();
    exp_q.delete();
    imm_a    = 12'($urandom());
    imm_a[0] = 1'b1; // Nonzero, so the second BEQ falls through
    xa   = sext12(imm_a);
    link = `SIM_PC_START + 64'd24;
    add_inst(enc_addi(5'd1, 5'd0, imm_a), 1'b1, 1'b1, 5'd1, xa);
    add_inst(enc_addi(5'd2, 5'd0, imm_a), 1'b1, 1'b1, 5'd2, xa);
    add_inst(enc_beq(5'd1, 5'd2, 13'd12), 1'b1, 1'b0, 5'd0, 64'd0);
    add_inst(enc_addi(5'd3, 5'd0, 12'd1), 1'b0, 1'b0, 5'd0, 64'd0);
    add_inst(enc_addi(5'd3, 5'd0, 12'd2), 1'b0, 1'b0, 5'd0, 64'd0);
    add_inst(enc_jal(5'd5, 21'd12), 1'b1, 1'b1, 5'd5, link);
    add_inst(enc_addi(5'd4, 5'd0, 12'd3), 1'b0, 1'b0, 5'd0, 64'd0);
    add_inst(enc_addi(5'd4, 5'd0, 12'd4), 1'b0, 1'b0, 5'd0, 64'd0);
    add_inst(enc_beq(5'd1, 5'd0, 13'd8), 1'b1, 1'b0, 5'd0, 64'd0);
    add_inst(enc_add(5'd6, 5'd5, 5'd1), 1'b1, 1'b1, 5'd6, link + xa);
    add_inst(enc_trap(), 1'b1, 1'b0, 5'd0, 64'd0);
    run_program(n);
  endtask

  task automatic trap_test();
    logic [7:0]  code;
    logic [11:0] imm_b;
    int          n;
    prog_q.delete();
    exp_q.delete();
    code  = 8'($urandom());
    imm_b = 12'($urandom());
    add_inst(enc_addi(5'd10, 5'd0, {4'h0, code}), 1'b1, 1'b1, 5'd10, {56'd0, code});
    add_inst(enc_addi(5'd11, 5'd10, imm_b), 1'b1, 1'b1, 5'd11,
             {56'd0, code} + sext12(imm_b));
    add_inst(enc_trap(), 1'b1, 1'b0, 5'd0, 64'd0);
    run_program(n);
    check_value("trap_o.code", 64'(trap_o.code), 64'(code));
    check_value("trap_o.pc", trap_o.pc, `SIM_PC_START + 64'd8);
    check_value("trap_o.instr_cnt", trap_o.instr_cnt, 64'(n));
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    seed        = $urandom(18316);
    clock       = 1'b0;
    reset       = 1'b1;
    run_i       = 1'b0;
    load_we_i   = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    idle_test();
    alu_test();
    memory_test();
    control_test();
    trap_test();
    $display("Test OK");
    $finish;
  end

endmodule

// File: all.f
+incdir+common
common/sim_pkg.sv
core/reg_file.sv
core/mini_core.sv
rtl/ram_bridge.sv
rtl/commit_monitor.sv
rtl/sim_top.sv
bench/tb_sim_top.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_sim_top
FILELIST := all.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
